//--- design/execMacros_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// operand and result width of the datapath.
`define WORD_WIDTH 32

// low bits of operand B that form a shift amount below the word width.
`define SHIFT_WIDTH 5

`define OP_WIDTH 4

`define MULT_STEPS 32 // one partial product per step.

`endif

//--- design/aluPkg.sv
`include "execMacros_macros.svh"

package aluPkg;

	// opcode order follows the instruction encoding of the pipeline.
	typedef enum logic [`OP_WIDTH-1:0] {
		opSll   = 4'd0,
		opSrl   = 4'd1,
		opSra   = 4'd2,
		opAdd   = 4'd3,
		opSub   = 4'd4,
		opOr    = 4'd5,
		opAnd   = 4'd6,
		opXor   = 4'd7,
		opSeq   = 4'd8,
		opSne   = 4'd9,
		opSlt   = 4'd10,
		opSgt   = 4'd11,
		opSle   = 4'd12,
		opSge   = 4'd13,
		opLhi   = 4'd14,
		opUndef = 4'd15
	} aluOp;

	typedef enum logic [2:0] {
		classShift    = 3'd0,
		classArith    = 3'd1,
		classLogic    = 3'd2,
		classCompare  = 3'd3,
		classLoadHigh = 3'd4,
		classNone     = 3'd5
	} aluClass;

	typedef struct packed {
		aluClass                opClass;
		aluOp                   op;
		logic [`WORD_WIDTH-1:0] operandA;
		logic [`WORD_WIDTH-1:0] operandB;
	} aluDecoded;

	typedef struct packed {
		logic                   valid;
		logic                   branch; // bit 0 of word.
		logic [`WORD_WIDTH-1:0] word;
	} aluResultT;

endpackage

//--- design/multPkg.sv
`include "execMacros_macros.svh"

package multPkg;

	// magnitude mode folds words above 2^31 back to their negation.
	typedef enum logic {
		plainMode     = 1'b0,
		magnitudeMode = 1'b1
	} multMode;

	typedef struct packed {
		multMode                mode;
		logic [`WORD_WIDTH-1:0] multiplicand;
		logic [`WORD_WIDTH-1:0] multiplier;
	} multRequest;

	typedef struct packed {
		logic                   done; // high for one cycle with the final word.
		logic [`WORD_WIDTH-1:0] word;
	} multResultT;

endpackage

//--- design/aluDecode.sv
`timescale 1ns/1ps
`include "execMacros_macros.svh"

module aluDecode (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic                   aluValid,
	input  aluPkg::aluOp           aluOpcode,
	input  logic [`WORD_WIDTH-1:0] operandA,
	input  logic [`WORD_WIDTH-1:0] operandB,
	output aluPkg::aluDecoded      decoded,
	output logic                   decodedValid
);
	aluPkg::aluClass        issueClass;
	aluPkg::aluClass        classQ;
	aluPkg::aluOp           opQ;
	logic                   validQ;
	logic [`WORD_WIDTH-1:0] operandAQ;
	logic [`WORD_WIDTH-1:0] operandBQ;

	// an idle slot decodes to none so the execute stage outputs zero.
	always_comb begin
		issueClass = aluPkg::classNone;
		if (aluValid) begin
			case (aluOpcode)
				aluPkg::opSll, aluPkg::opSrl, aluPkg::opSra: issueClass = aluPkg::classShift;
				aluPkg::opAdd, aluPkg::opSub:                issueClass = aluPkg::classArith;
				aluPkg::opOr, aluPkg::opAnd, aluPkg::opXor:  issueClass = aluPkg::classLogic;
				aluPkg::opSeq, aluPkg::opSne, aluPkg::opSlt,
				aluPkg::opSgt, aluPkg::opSle, aluPkg::opSge: issueClass = aluPkg::classCompare;
				aluPkg::opLhi:                               issueClass = aluPkg::classLoadHigh;
				default:                                     issueClass = aluPkg::classNone;
			endcase
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
			classQ <= aluPkg::classNone;
			opQ    <= aluPkg::opUndef;
		end else begin
			validQ <= aluValid; // a new operation may enter every cycle.
			classQ <= issueClass;
			opQ    <= aluOpcode;
		end
	end

	always_ff @(posedge clock) begin
		operandAQ <= operandA;
		operandBQ <= operandB;
	end

	assign decoded = '{opClass: classQ, op: opQ, operandA: operandAQ, operandB: operandBQ};
	assign decodedValid = validQ;

endmodule

//--- design/aluExecute.sv
`timescale 1ns/1ps
`include "execMacros_macros.svh"

module aluExecute (
	input  aluPkg::aluDecoded      decoded,
	output logic [`WORD_WIDTH-1:0] result
);
	localparam int halfWidth = `WORD_WIDTH / 2;

	logic [`WORD_WIDTH-1:0] a;
	logic [`WORD_WIDTH-1:0] b;
	logic [`SHIFT_WIDTH-1:0] shiftAmount;
	logic                   shiftInRange;
	logic [`WORD_WIDTH-1:0] shiftOut;
	logic [`WORD_WIDTH-1:0] arithOut;
	logic [`WORD_WIDTH-1:0] logicOut;
	logic [`WORD_WIDTH-1:0] compareOut;
	logic [`WORD_WIDTH-1:0] loadHighOut;

	assign a = decoded.operandA;
	assign b = decoded.operandB;

	// any bit above the shift field means the amount reaches the word width.
	assign shiftAmount  = b[`SHIFT_WIDTH-1:0];
	assign shiftInRange = ~|b[`WORD_WIDTH-1:`SHIFT_WIDTH];

	always_comb begin
		shiftOut = '0;
		case (decoded.op)
			aluPkg::opSll: if (shiftInRange) shiftOut = a << shiftAmount;
			aluPkg::opSrl: if (shiftInRange) shiftOut = a >> shiftAmount;
			aluPkg::opSra: begin
				if (shiftInRange)
					shiftOut = $signed(a) >>> shiftAmount;
				else
					shiftOut = {`WORD_WIDTH{a[`WORD_WIDTH-1]}}; // all sign bits.
			end
			default: shiftOut = '0;
		endcase
	end

	assign arithOut = (decoded.op == aluPkg::opSub) ? a - b : a + b;

	always_comb begin
		case (decoded.op)
			aluPkg::opOr:  logicOut = a | b;
			aluPkg::opAnd: logicOut = a & b;
			default:       logicOut = a ^ b;
		endcase
	end

	// compares are unsigned and only set bit 0.
	always_comb begin
		compareOut = '0;
		case (decoded.op)
			aluPkg::opSeq: compareOut[0] = (a == b);
			aluPkg::opSne: compareOut[0] = (a != b);
			aluPkg::opSlt: compareOut[0] = (a < b);
			aluPkg::opSgt: compareOut[0] = (a > b);
			aluPkg::opSle: compareOut[0] = (a <= b);
			aluPkg::opSge: compareOut[0] = (a >= b);
			default:       compareOut = '0;
		endcase
	end

	assign loadHighOut = {b[halfWidth-1:0], {halfWidth{1'b0}}};

	always_comb begin
		case (decoded.opClass)
			aluPkg::classShift:    result = shiftOut;
			aluPkg::classArith:    result = arithOut;
			aluPkg::classLogic:    result = logicOut;
			aluPkg::classCompare:  result = compareOut;
			aluPkg::classLoadHigh: result = loadHighOut;
			default:               result = '0;
		endcase
	end

endmodule

//--- design/aluResult.sv
`timescale 1ns/1ps
`include "execMacros_macros.svh"

module aluResult (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic                   decodedValid,
	input  logic [`WORD_WIDTH-1:0] result,
	output aluPkg::aluResultT      aluOut
);
	logic                   validQ;
	logic                   branchQ;
	logic [`WORD_WIDTH-1:0] wordQ;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			validQ  <= 1'b0;
			branchQ <= 1'b0;
			wordQ   <= '0;
		end else begin
			validQ  <= decodedValid;
			wordQ   <= result;
			// the flag is captured on the same edge as its word.
			branchQ <= result[0];
		end
	end

	assign aluOut = '{valid: validQ, branch: branchQ, word: wordQ};

endmodule

//--- design/shiftAddMultiplier.sv
`timescale 1ns/1ps
`include "execMacros_macros.svh"

module shiftAddMultiplier (
	input  logic                clock,
	input  logic                arstN,
	input  logic                multStart,
	input  multPkg::multRequest request,
	output multPkg::multResultT multOut,
	output logic                multBusy
);
	localparam int stepWidth = $clog2(`MULT_STEPS);
	localparam logic [stepWidth-1:0] lastStep = stepWidth'(`MULT_STEPS - 1);
	localparam logic [`WORD_WIDTH-1:0] signBoundary = {1'b1, {(`WORD_WIDTH-1){1'b0}}};

	logic                   busyQ;
	logic                   doneQ;
	logic [stepWidth-1:0]   stepQ;
	multPkg::multMode       modeQ;
	logic [`WORD_WIDTH-1:0] multiplicandQ;
	logic [`WORD_WIDTH-1:0] multiplierQ;
	logic [`WORD_WIDTH-1:0] accQ;
	logic [`WORD_WIDTH-1:0] wordQ;
	logic [`WORD_WIDTH-1:0] partial;
	logic [`WORD_WIDTH-1:0] accNext;
	logic [`WORD_WIDTH-1:0] finalWord;
	logic                   accept;

	assign accept = multStart && !busyQ; // a start while busy is dropped.

	// step i adds the multiplicand weighted by 2^i when multiplier bit i is set.
	assign partial = multiplierQ[stepQ] ? (multiplicandQ << stepQ) : '0;
	assign accNext = accQ + partial;

	always_comb begin
		finalWord = accNext;
		if (modeQ == multPkg::magnitudeMode && accNext > signBoundary)
			finalWord = '0 - accNext;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			busyQ <= 1'b0;
			doneQ <= 1'b0;
			stepQ <= '0;
			wordQ <= '0;
		end else begin
			doneQ <= 1'b0;
			if (accept) begin
				busyQ <= 1'b1;
				stepQ <= '0;
			end else if (busyQ) begin
				stepQ <= stepQ + 1'b1;
				if (stepQ == lastStep) begin
					busyQ <= 1'b0;
					doneQ <= 1'b1;
					wordQ <= finalWord; // the word is held until the next multiply ends.
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			modeQ         <= request.mode;
			multiplicandQ <= request.multiplicand;
			multiplierQ   <= request.multiplier;
			accQ          <= '0;
		end else if (busyQ) begin
			accQ <= accNext;
		end
	end

	assign multOut  = '{done: doneQ, word: wordQ};
	assign multBusy = busyQ;

endmodule

//--- design/executeUnit.sv
`timescale 1ns/1ps
`include "execMacros_macros.svh"

module executeUnit (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic                   aluValid,
	input  aluPkg::aluOp           aluOpcode,
	input  logic [`WORD_WIDTH-1:0] operandA,
	input  logic [`WORD_WIDTH-1:0] operandB,
	input  logic                   multStart,
	input  multPkg::multRequest    multReq,
	output aluPkg::aluResultT      aluOut,
	output multPkg::multResultT    multOut,
	output logic                   multBusy
);
	aluPkg::aluDecoded      decoded;
	logic                   decodedValid;
	logic [`WORD_WIDTH-1:0] executeWord;

	// the ALU path has two stages and returns one result per cycle.
	aluDecode decodeStage (
		.clock        (clock),
		.arstN        (arstN),
		.aluValid     (aluValid),
		.aluOpcode    (aluOpcode),
		.operandA     (operandA),
		.operandB     (operandB),
		.decoded      (decoded),
		.decodedValid (decodedValid)
	);

	aluExecute executeStage (
		.decoded (decoded),
		.result  (executeWord)
	);

	aluResult resultStage (
		.clock        (clock),
		.arstN        (arstN),
		.decodedValid (decodedValid),
		.result       (executeWord),
		.aluOut       (aluOut)
	);

	// the multiplier runs beside the ALU and never stalls it.
	shiftAddMultiplier multiplier (
		.clock     (clock),
		.arstN     (arstN),
		.multStart (multStart),
		.request   (multReq),
		.multOut   (multOut),
		.multBusy  (multBusy)
	);

endmodule

//--- test/executeUnitTb.sv
`timescale 1ns/1ps
`include "execMacros_macros.svh"

module executeUnitTb;

	logic                   clock;
	logic                   arstN;
	logic                   aluValid;
	aluPkg::aluOp           aluOpcode;
	logic [`WORD_WIDTH-1:0] operandA;
	logic [`WORD_WIDTH-1:0] operandB;
	logic                   multStart;
	multPkg::multRequest    multReq;
	aluPkg::aluResultT      aluOut;
	multPkg::multResultT    multOut;
	logic                   multBusy;

	int                     cycleCount = 0;
	int                     cycleLimit = 0;
	logic [8*256-1:0]       lineBuf;

	// expected ALU results wait here in issue order together with the cycle each one is due.
	logic [`WORD_WIDTH-1:0] expWords[$];
	int                     dueCycles[$];
	string                  names[$];

	executeUnit DUT (
		.clock     (clock),
		.arstN     (arstN),
		.aluValid  (aluValid),
		.aluOpcode (aluOpcode),
		.operandA  (operandA),
		.operandB  (operandB),
		.multStart (multStart),
		.multReq   (multReq),
		.aluOut    (aluOut),
		.multOut   (multOut),
		.multBusy  (multBusy)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task stopRun(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task checkAlu(input string testName, input aluPkg::aluResultT expected,
			input aluPkg::aluResultT actual);
		if (actual !== expected)
			stopRun({$sformatf("Mismatch %s: expected valid=%0b branch=%0b word=%h, ",
				testName, expected.valid, expected.branch, expected.word),
				$sformatf("actual valid=%0b branch=%0b word=%h",
				actual.valid, actual.branch, actual.word)});
	endtask

	task checkMult(input string testName, input multPkg::multResultT expected,
			input multPkg::multResultT actual);
		if (actual !== expected)
			stopRun($sformatf("Mismatch %s: expected done=%0b word=%h, actual done=%0b word=%h",
				testName, expected.done, expected.word, actual.done, actual.word));
	endtask

	// every line of the trace starts with one kind character.
	task countRecords(output int count);
		int         fd;
		int         code;
		int         dummy;
		logic [7:0] kind;
		logic       atEnd;
		count = 0;
		atEnd = 1'b0;
		fd = $fopen("test/executeTrace.dat", "r");
		if (fd == 0)
			stopRun("could not open the trace file test/executeTrace.dat");
		while (!atEnd) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1) begin
				atEnd = 1'b1;
			end else begin
				dummy = $fgets(lineBuf, fd);
				if (kind == "A" || kind == "M")
					count++;
			end
		end
		$fclose(fd);
	endtask

	task runMult(input string testName, input multPkg::multRequest req,
			input logic [`WORD_WIDTH-1:0] expWord);
		int                  stepCount;
		logic                doneSeen;
		multPkg::multResultT expected;
		multPkg::multRequest ignored;
		ignored = '{mode: multPkg::multMode'(~req.mode), multiplicand: ~req.multiplicand,
			multiplier: ~req.multiplier};
		@(posedge clock);
		#2;
		aluValid  = 1'b0;
		multStart = 1'b1;
		multReq   = req;
		@(posedge clock); // accepting edge.
		#2 multStart = 1'b0;
		@(negedge clock);
		if (!multBusy)
			stopRun($sformatf("%s: multBusy stayed low after the accepting edge", testName));
		stepCount = 0;
		doneSeen  = 1'b0;
		while (!doneSeen) begin
			@(posedge clock);
			stepCount++;
			#2;
			if (stepCount == 4) begin
				multStart = 1'b1; // a busy multiplier must drop this request.
				multReq   = ignored;
			end else begin
				multStart = 1'b0;
			end
			@(negedge clock);
			if (multOut.done)
				doneSeen = 1'b1;
			else if (!multBusy)
				stopRun($sformatf("%s: multBusy went low before done", testName));
		end
		if (stepCount != `MULT_STEPS)
			stopRun($sformatf("%s: done came %0d edges after the start instead of %0d",
				testName, stepCount, `MULT_STEPS));
		expected = '{done: 1'b1, word: expWord};
		checkMult(testName, expected, multOut);
		if (multBusy)
			stopRun($sformatf("%s: multBusy still high while done is high", testName));
		@(negedge clock);
		if (multOut.done)
			stopRun($sformatf("%s: done stayed high for more than one cycle", testName));
	endtask

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit)
			stopRun($sformatf("timeout after %0d cycles, the run did not finish", cycleLimit));
	end

	// results are sampled at the falling edge while they are stable.
	always @(negedge clock) begin : aluMonitor
		string                  name;
		logic [`WORD_WIDTH-1:0] word;
		int                     due;
		aluPkg::aluResultT      expected;
		if (aluOut.valid) begin
			if (dueCycles.size() == 0)
				stopRun("an ALU result appeared with no operation in flight");
			name = names.pop_front();
			word = expWords.pop_front();
			due  = dueCycles.pop_front();
			if (due != cycleCount)
				stopRun($sformatf("%s: ALU result came at cycle %0d instead of cycle %0d",
					name, cycleCount, due));
			expected = '{valid: 1'b1, branch: word[0], word: word}; // flag is bit 0.
			checkAlu(name, expected, aluOut);
		end else if (dueCycles.size() != 0 && dueCycles[0] <= cycleCount) begin
			stopRun($sformatf("%s: ALU result missing at cycle %0d", names[0], dueCycles[0]));
		end
	end

	initial begin : driver
		int                     fd;
		int                     code;
		int                     recordCount;
		int                     lineNo;
		logic                   atEnd;
		logic [7:0]             kind;
		logic [31:0]            field;
		logic [`WORD_WIDTH-1:0] valA;
		logic [`WORD_WIDTH-1:0] valB;
		logic [`WORD_WIDTH-1:0] expWord;
		multPkg::multRequest    req;
		aluPkg::aluResultT      aluIdle;
		multPkg::multResultT    multIdle;
		arstN     = 1'b0;
		aluValid  = 1'b0;
		aluOpcode = aluPkg::opUndef;
		operandA  = '0;
		operandB  = '0;
		multStart = 1'b0;
		multReq   = '0;
		aluIdle   = '{valid: 1'b0, branch: 1'b0, word: '0};
		multIdle  = '{done: 1'b0, word: '0};
		countRecords(recordCount);
		if (recordCount == 0)
			stopRun("the trace file holds no records");
		cycleLimit = 40 * recordCount + 100;
		repeat (3) @(posedge clock);
		#2 arstN = 1'b1;
		@(negedge clock);
		checkAlu("reset", aluIdle, aluOut);
		checkMult("reset", multIdle, multOut);
		if (multBusy)
			stopRun("multBusy is high after reset");
		fd = $fopen("test/executeTrace.dat", "r");
		if (fd == 0)
			stopRun("could not open the trace file test/executeTrace.dat");
		lineNo = 0;
		atEnd  = 1'b0;
		while (!atEnd) begin
			code = $fscanf(fd, " %c", kind);
			lineNo++;
			if (code != 1) begin
				atEnd = 1'b1;
			end else if (kind == "#") begin
				code = $fgets(lineBuf, fd); // comment line.
			end else begin
				code = $fscanf(fd, "%h %h %h %h", field, valA, valB, expWord);
				if (code != 4)
					stopRun($sformatf("trace line %0d is malformed", lineNo));
				if (kind == "A") begin
					@(posedge clock);
					#2;
					aluValid  = 1'b1; // operations issue back to back on consecutive cycles.
					aluOpcode = aluPkg::aluOp'(field[3:0]);
					operandA  = valA;
					operandB  = valB;
					names.push_back($sformatf("line %0d alu op %0d", lineNo, field[3:0]));
					expWords.push_back(expWord);
					dueCycles.push_back(cycleCount + 2);
				end else if (kind == "M") begin
					req = '{mode: multPkg::multMode'(field[0]), multiplicand: valA,
						multiplier: valB};
					runMult($sformatf("line %0d mult mode %0d", lineNo, field[0]),
						req, expWord);
				end else begin
					stopRun($sformatf("trace line %0d has an unknown record kind", lineNo));
				end
			end
		end
		$fclose(fd);
		@(posedge clock);
		#2 aluValid = 1'b0;
		while (dueCycles.size() != 0)
			@(negedge clock);
		repeat (2) @(negedge clock);
		$display("Test OK");
		$finish;
	end

endmodule

//--- test/executeTrace.dat
# A opcode operandA operandB expectedWord, all hex.
# M mode multiplicand multiplier expectedWord, mode 0 plain and 1 magnitude.
A 0 00000001 00000004 00000010
A 0 80000001 0000001f 80000000
A 0 ffffffff 00000020 00000000
A 1 80000000 0000001f 00000001
A 1 12345678 00000100 00000000
A 2 80000000 00000004 f8000000
A 2 80000000 00000040 ffffffff
A 2 7fffffff 00000021 00000000
A 3 ffffffff 00000001 00000000
A 3 12345678 11111111 23456789
A 4 00000000 00000001 ffffffff
A 5 f0f00000 0000f0f1 f0f0f0f1
A 6 ff00ff00 0ff00ff1 0f000f00
A 7 aaaaaaaa 55555555 ffffffff
A 8 deadbeef deadbeef 00000001
A 8 deadbeef deadbeee 00000000
A 9 00000001 00000002 00000001
A a 00000001 ffffffff 00000001
A a 80000000 00000001 00000000
A b 80000000 7fffffff 00000001
A b 00000003 00000003 00000000
A c 00000003 00000003 00000001
A d 00000002 00000003 00000000
A d fffffffe fffffffe 00000001
A e ffffffff 0000abcd abcd0000
A f 12345678 9abcdef0 00000000
M 0 00000003 00000007 00000015
M 0 0000ffff 0000ffff fffe0001
M 0 12345678 00000000 00000000
M 0 ffffffff 00000002 fffffffe
M 1 ffffffff 00000002 00000002
M 1 00010000 00008000 80000000
M 1 7fffffff 00000003 7ffffffd
M 1 00000001 80000001 7fffffff

//--- build.f
+incdir+design
design/aluPkg.sv
design/multPkg.sv
design/aluDecode.sv
design/aluExecute.sv
design/aluResult.sv
design/shiftAddMultiplier.sv
design/executeUnit.sv
test/executeUnitTb.sv

//--- runSim.sh
#!/bin/sh
# Compiles the execute unit testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module executeUnitTb -o simExecuteUnit
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "verilator build failed with status $buildStatus"
	exit 1
fi

simOutput=$(./obj_dir/simExecuteUnit 2>&1)
runStatus=$?
printf '%s\n' "$simOutput"
if [ $runStatus -ne 0 ]; then
	echo "simulation exited with status $runStatus"
	exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "Test OK"; then
	exit 0
fi
exit 1
